// ==== common/soc_pkg.sv ====
// Shared address map, widths, register offsets and device table entry layout for the SoC fabric
`default_nettype none

package soc_pkg;

	// Bus widths
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;
	localparam int ADDR_W = 12;

	// Word address splits into slot (11..8) and offset (7..0)
	localparam int SLOT_LSB = 8;
	localparam int SLOT_W = ADDR_W - SLOT_LSB;
	localparam int SLOT_COUNT = 2 ** SLOT_W;

	localparam logic [SLOT_W-1:0] SLOT_DEVTBL = 4'd0;
	localparam logic [SLOT_W-1:0] SLOT_INTCTRL = 4'd1;
	localparam logic [SLOT_W-1:0] SLOT_RAM = 4'd2;

	// Device table entry fields
	localparam int DEV_ID_W = 8;
	localparam int MAPSZ_W = 16;

	localparam logic [DEV_ID_W-1:0] DEV_ID_DEVTBL = 8'd7;
	localparam logic [DEV_ID_W-1:0] DEV_ID_INTCTRL = 8'd3;
	localparam logic [DEV_ID_W-1:0] DEV_ID_RAM = 8'd1;
	localparam logic [DEV_ID_W-1:0] DEV_ID_NONE = 8'd0;

	// Every mapped device spans the whole slot
	localparam logic [MAPSZ_W-1:0] DEV_MAPSZ = 16'd256;

	// Interrupt sources, claim value is index plus one
	localparam int IRQ_SRC_COUNT = 2;
	localparam int IRQ_ID_W = $clog2(IRQ_SRC_COUNT + 1);

	// Reset stretch
	localparam int RST_CNT_CYCLES = 16;
	localparam int RST_CNT_W = $clog2(RST_CNT_CYCLES + 1);

	// Register offsets inside a slot
	localparam logic [SLOT_LSB-1:0] DEVTBL_RST_OFS = 8'd255;
	localparam logic [SLOT_LSB-1:0] INT_ENABLE_OFS = 8'd0;
	localparam logic [SLOT_LSB-1:0] INT_PENDING_OFS = 8'd1;
	localparam logic [SLOT_LSB-1:0] INT_CLAIM_OFS = 8'd2;

	// Identifier sits in the low byte, map size in the high half
	typedef struct packed {
		logic [MAPSZ_W-1:0] mapsz;
		logic [6:0] rsvd;
		logic useintr;
		logic [DEV_ID_W-1:0] id;
	} devtbl_fields_t;

	typedef union packed {
		logic [DATA_W-1:0] raw;
		devtbl_fields_t fields;
	} devtbl_entry_u;

endpackage

`default_nettype wire

// ==== hdl/bus_decode.sv ====
// Wishbone slot decoder: routes strobes by address slot, muxes ack and data back, owns the default slave
`default_nettype none

module bus_decode (
	input  logic                       clk48mhz_i,
	input  logic                       rst_p,
	input  logic                       cyc_i,
	input  logic                       stb_i,
	input  logic [soc_pkg::ADDR_W-1:0] adr_i,
	input  logic                       ack_devtbl_i,
	input  logic [soc_pkg::DATA_W-1:0] dat_devtbl_i,
	input  logic                       ack_intctrl_i,
	input  logic [soc_pkg::DATA_W-1:0] dat_intctrl_i,
	input  logic                       ack_ram_i,
	input  logic [soc_pkg::DATA_W-1:0] dat_ram_i,
	output logic                       stb_devtbl_o,
	output logic                       stb_intctrl_o,
	output logic                       stb_ram_o,
	output logic                       ack_o,
	output logic [soc_pkg::DATA_W-1:0] dat_o
);
	import soc_pkg::*;

	logic [SLOT_W-1:0] slot;
	logic stb_dflt;
	logic ack_dflt_q;

	assign slot = adr_i[ADDR_W-1:SLOT_LSB];

	// Exactly one strobe follows stb_i, data and ack come back unregistered
	always_comb begin
		stb_devtbl_o = 1'b0;
		stb_intctrl_o = 1'b0;
		stb_ram_o = 1'b0;
		stb_dflt = 1'b0;
		ack_o = ack_dflt_q;
		dat_o = '0;
		case (slot)
			SLOT_DEVTBL: begin
				stb_devtbl_o = stb_i;
				ack_o = ack_devtbl_i;
				dat_o = dat_devtbl_i;
			end
			SLOT_INTCTRL: begin
				stb_intctrl_o = stb_i;
				ack_o = ack_intctrl_i;
				dat_o = dat_intctrl_i;
			end
			SLOT_RAM: begin
				stb_ram_o = stb_i;
				ack_o = ack_ram_i;
				dat_o = dat_ram_i;
			end
			default: begin
				// Unmapped slot reads as zero
				stb_dflt = stb_i;
			end
		endcase
	end

	// Default slave acks like any other device and drops writes
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			ack_dflt_q <= 1'b0;
		end else begin
			ack_dflt_q <= cyc_i & stb_dflt & ~ack_dflt_q;
		end
	end

endmodule

`default_nettype wire

// ==== devtbl/devtbl.sv ====
// Device table slave: read-only slot descriptors plus the software reset register that drives reset_seq
`default_nettype none

module devtbl (
	input  logic                         clk48mhz_i,
	input  logic                         rst_p,
	input  logic                         cyc_i,
	input  logic                         stb_i,
	input  logic                         we_i,
	input  logic [soc_pkg::SLOT_LSB-1:0] adr_i,
	input  logic [soc_pkg::DATA_W-1:0]   dat_i,
	input  logic [soc_pkg::SEL_W-1:0]    sel_i,
	output logic                         ack_o,
	output logic [soc_pkg::DATA_W-1:0]   dat_o,
	output logic                         rst0_o,
	output logic                         rst1_o
);
	import soc_pkg::*;

	logic ack_q;
	logic [DATA_W-1:0] dat_q;
	logic rst0_q;
	logic rst1_q;
	logic acc;
	logic [DATA_W-1:0] rd_word;

	// Descriptor of one slot, all zero when nothing is mapped there
	function automatic logic [DATA_W-1:0] entry_of(input logic [SLOT_W-1:0] slot);
		devtbl_entry_u e;
		e.raw = '0;
		e.fields.id = DEV_ID_NONE;
		case (slot)
			SLOT_DEVTBL: begin
				e.fields.id = DEV_ID_DEVTBL;
				e.fields.mapsz = DEV_MAPSZ;
			end
			SLOT_INTCTRL: begin
				e.fields.id = DEV_ID_INTCTRL;
				e.fields.useintr = 1'b1;
				e.fields.mapsz = DEV_MAPSZ;
			end
			SLOT_RAM: begin
				e.fields.id = DEV_ID_RAM;
				e.fields.mapsz = DEV_MAPSZ;
			end
			default: e.raw = '0;
		endcase
		return e.raw;
	endfunction

	assign acc = cyc_i & stb_i & ~ack_q;

	always_comb begin
		if (adr_i == DEVTBL_RST_OFS) begin
			rd_word = {{(DATA_W-2){1'b0}}, rst1_q, rst0_q};
		end else if (int'(adr_i) < SLOT_COUNT) begin
			rd_word = entry_of(adr_i[SLOT_W-1:0]);
		end else begin
			rd_word = '0;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			ack_q <= 1'b0;
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else begin
			ack_q <= acc;
			// Reset bits live in byte lane 0
			if (acc && we_i && sel_i[0] && adr_i == DEVTBL_RST_OFS) begin
				rst0_q <= dat_i[0];
				rst1_q <= dat_i[1];
			end
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (acc) begin
			dat_q <= rd_word;
		end
	end

	assign ack_o = ack_q;
	assign dat_o = dat_q;
	assign rst0_o = rst0_q;
	assign rst1_o = rst1_q;

endmodule

`default_nettype wire

// ==== hdl/reset_seq.sv ====
// Reset sequencer: merges board reset with software reset requests and stretches the system reset
`default_nettype none

module reset_seq (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);
	import soc_pkg::*;

	logic warm_rst;
	logic pwr_off;
	logic pwroff_q;
	logic [RST_CNT_W-1:0] cnt_q;
	// Powers up asserted so the fabric never runs before the first board reset
	logic sys_rst_q = 1'b1;

	// Both bits set would be a cold reset, which has no effect here
	assign warm_rst = rst1_i & ~rst0_i;
	assign pwr_off = rst0_i & ~rst1_i;

	// Stretch counter reloads on board reset or warm reset
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || warm_rst) begin
			cnt_q <= RST_CNT_W'(RST_CNT_CYCLES);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Power-off holds the system down until the board reset
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwr_off) begin
			pwroff_q <= 1'b1;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		sys_rst_q <= rst_p | warm_rst | pwr_off | pwroff_q | (cnt_q != '0);
	end

	assign sys_rst_o = sys_rst_q;

endmodule

`default_nettype wire

// ==== intctrl/intctrl.sv ====
// Interrupt controller slave with edge-triggered pending bits, enable mask and claim register, driving one request line
`default_nettype none

module intctrl (
	input  logic                              clk48mhz_i,
	input  logic                              rst_p,
	input  logic                              cyc_i,
	input  logic                              stb_i,
	input  logic                              we_i,
	input  logic [soc_pkg::SLOT_LSB-1:0]      adr_i,
	input  logic [soc_pkg::DATA_W-1:0]        dat_i,
	input  logic [soc_pkg::SEL_W-1:0]         sel_i,
	input  logic [soc_pkg::IRQ_SRC_COUNT-1:0] irq_src_i,
	output logic                              ack_o,
	output logic [soc_pkg::DATA_W-1:0]        dat_o,
	output logic                              irq_o
);
	import soc_pkg::*;

	logic ack_q;
	logic [DATA_W-1:0] dat_q;
	logic irq_q;
	logic [IRQ_SRC_COUNT-1:0] src_q;
	logic [IRQ_SRC_COUNT-1:0] pending_q;
	logic [IRQ_SRC_COUNT-1:0] enable_q;
	logic [IRQ_SRC_COUNT-1:0] active;
	logic [IRQ_SRC_COUNT-1:0] rise;
	logic [IRQ_SRC_COUNT-1:0] claim_mask;
	logic [IRQ_SRC_COUNT-1:0] clr;
	logic [IRQ_ID_W-1:0] claim_id;
	logic acc;
	logic wr_enable;
	logic wr_pending;
	logic rd_claim;
	logic [DATA_W-1:0] rd_word;

	assign acc = cyc_i & stb_i & ~ack_q;
	assign wr_enable = acc & we_i & sel_i[0] & (adr_i == INT_ENABLE_OFS);
	assign wr_pending = acc & we_i & sel_i[0] & (adr_i == INT_PENDING_OFS);
	assign rd_claim = acc & ~we_i & (adr_i == INT_CLAIM_OFS);

	assign rise = irq_src_i & ~src_q;
	assign active = pending_q & enable_q;

	// Lowest enabled pending source wins the claim
	always_comb begin
		claim_id = '0;
		claim_mask = '0;
		for (int i = IRQ_SRC_COUNT - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_id = IRQ_ID_W'(i + 1);
				claim_mask = IRQ_SRC_COUNT'(1) << i;
			end
		end
	end

	// Ones written to pending clear those bits while a new edge in the same cycle still sets them
	assign clr = (wr_pending ? dat_i[IRQ_SRC_COUNT-1:0] : '0) | (rd_claim ? claim_mask : '0);

	always_comb begin
		case (adr_i)
			INT_ENABLE_OFS: rd_word = {{(DATA_W-IRQ_SRC_COUNT){1'b0}}, enable_q};
			INT_PENDING_OFS: rd_word = {{(DATA_W-IRQ_SRC_COUNT){1'b0}}, pending_q};
			INT_CLAIM_OFS: rd_word = {{(DATA_W-IRQ_ID_W){1'b0}}, claim_id};
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk48mhz_i) begin
		src_q <= irq_src_i;
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			ack_q <= 1'b0;
			pending_q <= '0;
			enable_q <= '0;
			irq_q <= 1'b0;
		end else begin
			ack_q <= acc;
			pending_q <= (pending_q & ~clr) | rise;
			if (wr_enable) begin
				enable_q <= dat_i[IRQ_SRC_COUNT-1:0];
			end
			irq_q <= |active;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (acc) begin
			dat_q <= rd_word;
		end
	end

	assign ack_o = ack_q;
	assign dat_o = dat_q;
	// Request drops as soon as the system reset rises
	assign irq_o = irq_q & ~rst_p;

endmodule

`default_nettype wire

// ==== hdl/scratch_ram.sv ====
// Scratch RAM slave with byte lanes, standing in for main memory on the Wishbone fabric
`default_nettype none

module scratch_ram (
	input  logic                         clk48mhz_i,
	input  logic                         cyc_i,
	input  logic                         stb_i,
	input  logic                         we_i,
	input  logic [soc_pkg::SLOT_LSB-1:0] adr_i,
	input  logic [soc_pkg::DATA_W-1:0]   dat_i,
	input  logic [soc_pkg::SEL_W-1:0]    sel_i,
	output logic                         ack_o,
	output logic [soc_pkg::DATA_W-1:0]   dat_o
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem [0:DEV_MAPSZ-1];
	logic [DATA_W-1:0] dat_q;
	// Contents and ack survive the system reset
	logic ack_q = 1'b0;
	logic acc;

	assign acc = cyc_i & stb_i & ~ack_q;

	always_ff @(posedge clk48mhz_i) begin
		ack_q <= acc;
		if (acc) begin
			dat_q <= mem[adr_i];
			if (we_i) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (sel_i[b]) begin
						mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end
			end
		end
	end

	assign ack_o = ack_q;
	assign dat_o = dat_q;

endmodule

`default_nettype wire

// ==== hdl/soc_top.sv ====
// SoC peripheral top level: bus fabric, device table, interrupt controller, scratch RAM and reset sequencer
`default_nettype none

module soc_top (
	input  logic                              clk48mhz_i,
	input  logic                              rst_p,
	input  logic                              cyc_i,
	input  logic                              stb_i,
	input  logic                              we_i,
	input  logic [soc_pkg::ADDR_W-1:0]        adr_i,
	input  logic [soc_pkg::DATA_W-1:0]        dat_i,
	input  logic [soc_pkg::SEL_W-1:0]         sel_i,
	input  logic [soc_pkg::IRQ_SRC_COUNT-1:0] irq_src_i,
	output logic                              ack_o,
	output logic [soc_pkg::DATA_W-1:0]        dat_o,
	output logic                              irq_o,
	output logic                              sys_rst_o
);
	import soc_pkg::*;

	logic stb_devtbl;
	logic stb_intctrl;
	logic stb_ram;
	logic ack_devtbl;
	logic ack_intctrl;
	logic ack_ram;
	logic [DATA_W-1:0] dat_devtbl;
	logic [DATA_W-1:0] dat_intctrl;
	logic [DATA_W-1:0] dat_ram;
	logic rst0;
	logic rst1;

	bus_decode bus_decode_i (
		.clk48mhz_i   (clk48mhz_i),
		.rst_p        (sys_rst_o),
		.cyc_i        (cyc_i),
		.stb_i        (stb_i),
		.adr_i        (adr_i),
		.ack_devtbl_i (ack_devtbl),
		.dat_devtbl_i (dat_devtbl),
		.ack_intctrl_i(ack_intctrl),
		.dat_intctrl_i(dat_intctrl),
		.ack_ram_i    (ack_ram),
		.dat_ram_i    (dat_ram),
		.stb_devtbl_o (stb_devtbl),
		.stb_intctrl_o(stb_intctrl),
		.stb_ram_o    (stb_ram),
		.ack_o        (ack_o),
		.dat_o        (dat_o)
	);

	devtbl devtbl_i (
		.clk48mhz_i(clk48mhz_i),
		.rst_p     (sys_rst_o),
		.cyc_i     (cyc_i),
		.stb_i     (stb_devtbl),
		.we_i      (we_i),
		.adr_i     (adr_i[SLOT_LSB-1:0]),
		.dat_i     (dat_i),
		.sel_i     (sel_i),
		.ack_o     (ack_devtbl),
		.dat_o     (dat_devtbl),
		.rst0_o    (rst0),
		.rst1_o    (rst1)
	);

	// Board reset goes here only, everything else runs on the stretched reset
	reset_seq reset_seq_i (
		.clk48mhz_i(clk48mhz_i),
		.rst_p     (rst_p),
		.rst0_i    (rst0),
		.rst1_i    (rst1),
		.sys_rst_o (sys_rst_o)
	);

	intctrl intctrl_i (
		.clk48mhz_i(clk48mhz_i),
		.rst_p     (sys_rst_o),
		.cyc_i     (cyc_i),
		.stb_i     (stb_intctrl),
		.we_i      (we_i),
		.adr_i     (adr_i[SLOT_LSB-1:0]),
		.dat_i     (dat_i),
		.sel_i     (sel_i),
		.irq_src_i (irq_src_i),
		.ack_o     (ack_intctrl),
		.dat_o     (dat_intctrl),
		.irq_o     (irq_o)
	);

	scratch_ram scratch_ram_i (
		.clk48mhz_i(clk48mhz_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_ram),
		.we_i      (we_i),
		.adr_i     (adr_i[SLOT_LSB-1:0]),
		.dat_i     (dat_i),
		.sel_i     (sel_i),
		.ack_o     (ack_ram),
		.dat_o     (dat_ram)
	);

endmodule

`default_nettype wire

// ==== bench/soc_chk.sv ====
// Protocol checker bound into soc_top, watching the Wishbone handshake and the interrupt line
`default_nettype none

module soc_chk (
	input wire logic clk48mhz_i,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire logic ack_o,
	input wire logic irq_o,
	input wire logic sys_rst_o
);

	int fail_count = 0;

	// Ack only answers a live request
	ack_needs_request: assert property (@(posedge clk48mhz_i) ack_o |-> (cyc_i && stb_i))
		else begin
			$error("ack_o high without cyc_i and stb_i");
			fail_count++;
		end

	// Classic handshake acks for one cycle only
	ack_single_cycle: assert property (@(posedge clk48mhz_i) ack_o |=> !ack_o)
		else begin
			$error("ack_o high for two cycles");
			fail_count++;
		end

	irq_quiet_in_reset: assert property (@(posedge clk48mhz_i) sys_rst_o |-> !irq_o)
		else begin
			$error("irq_o high during system reset");
			fail_count++;
		end

endmodule

`default_nettype wire

// ==== bench/soc_tb.sv ====
// Testbench for soc_top that acts as the only Wishbone master and walks a stimulus table
`default_nettype none

module soc_tb;
	import soc_pkg::*;

	typedef enum logic [2:0] {OP_RD, OP_WR, OP_PULSE, OP_IRQ, OP_WAITRST, OP_HOLD, OP_BOARD} op_e;

	logic clk48mhz_i, rst_p, cyc_i, stb_i, we_i, ack_o, irq_o, sys_rst_o;
	logic [ADDR_W-1:0] adr_i;
	logic [DATA_W-1:0] dat_i, dat_o;
	logic [SEL_W-1:0] sel_i;
	logic [IRQ_SRC_COUNT-1:0] irq_src_i;

	op_e t_op [$];
	logic [ADDR_W-1:0] t_adr [$];
	logic [DATA_W-1:0] t_dat [$];
	logic [SEL_W-1:0] t_sel [$];
	logic [DATA_W-1:0] t_exp [$];
	int errors = 0;
	logic table_ready = 1'b0;

	soc_top dut_i (.*);

	bind soc_top soc_chk chk_i (.clk48mhz_i(clk48mhz_i), .cyc_i(cyc_i), .stb_i(stb_i),
		.ack_o(ack_o), .irq_o(irq_o), .sys_rst_o(sys_rst_o));

	initial begin
		clk48mhz_i = 1'b0;
		forever #10 clk48mhz_i = ~clk48mhz_i;
	end

	task automatic add_row(input op_e op, input int adr, input logic [DATA_W-1:0] dat,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] exp);
		t_op.push_back(op);
		t_adr.push_back(ADDR_W'(adr));
		t_dat.push_back(dat);
		t_sel.push_back(sel);
		t_exp.push_back(exp);
	endtask

	// Expected descriptor with id in the low byte, interrupt use in bit 8 and map size on top
	function automatic logic [DATA_W-1:0] expected_entry(input int slot);
		case (slot)
			0: return {DEV_MAPSZ, 8'h00, DEV_ID_DEVTBL};
			1: return {DEV_MAPSZ, 8'h01, DEV_ID_INTCTRL};
			2: return {DEV_MAPSZ, 8'h00, DEV_ID_RAM};
			default: return '0;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_w,
			input logic [DATA_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] r;
		r = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) r[8*b +: 8] = new_w[8*b +: 8];
		end
		return r;
	endfunction

	task automatic check_value(input string what, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		assert (got === exp) else begin
			$display("error at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
			output logic [DATA_W-1:0] rdata);
		int n;
		n = 0;
		@(posedge clk48mhz_i);
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i <= we;
		adr_i <= adr;
		dat_i <= dat;
		sel_i <= sel;
		@(negedge clk48mhz_i);
		while (!ack_o && n < 8) begin
			@(negedge clk48mhz_i);
			n++;
		end
		rdata = dat_o;
		if (!ack_o) begin
			$display("No ack within 8 cycles for address %h at time %0t", adr, $time);
			errors++;
		end
		@(posedge clk48mhz_i);
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
	endtask

	// Counts cycles from the first edge with the board reset released until sys_rst_o falls
	task automatic wait_release(input bit strict);
		int n;
		n = 0;
		do begin
			@(posedge clk48mhz_i);
			n++;
			@(negedge clk48mhz_i);
			check_value("irq_o in reset", irq_o, 0);
			check_value("ack_o in reset", ack_o, 0);
		end while (sys_rst_o && n < 4 * RST_CNT_CYCLES);
		if (sys_rst_o) begin
			$display("System reset never released at time %0t", $time);
			errors++;
		end
		if (strict) check_value("reset stretch cycles", n, RST_CNT_CYCLES + 1);
	endtask

	task automatic board_reset();
		@(posedge clk48mhz_i);
		rst_p <= 1'b1;
		repeat (3) @(posedge clk48mhz_i);
		rst_p <= 1'b0;
		@(negedge clk48mhz_i);
		check_value("sys_rst_o during board reset", sys_rst_o, 1);
		wait_release(1'b1);
	endtask

	task automatic build_table();
		logic [DATA_W-1:0] rnd;
		logic [SEL_W-1:0] rsel;
		logic [DATA_W-1:0] ram_word;
		rnd = $urandom;
		rsel = SEL_W'($urandom);
		ram_word = merge_lanes(32'h11223344, rnd, rsel);
		for (int s = 0; s < SLOT_COUNT; s++) add_row(OP_RD, s, 0, 4'hf, expected_entry(s));
		add_row(OP_WR, 'h205, 32'h11223344, 4'hf, 0);
		add_row(OP_WR, 'h205, rnd, rsel, 0);
		add_row(OP_RD, 'h205, 0, 4'hf, ram_word);
		add_row(OP_RD, 'h300, 0, 4'hf, 0);
		add_row(OP_WR, 'h305, 32'hdeadbeef, 4'hf, 0);
		add_row(OP_RD, 'h305, 0, 4'hf, 0);
		add_row(OP_RD, 'h205, 0, 4'hf, ram_word);
		add_row(OP_RD, 'hf00, 0, 4'hf, 0);
		add_row(OP_WR, 'h100, 3, 4'hf, 0);
		add_row(OP_PULSE, 0, 2, 0, 1);
		add_row(OP_PULSE, 0, 1, 0, 1);
		add_row(OP_RD, 'h101, 0, 4'hf, 3);
		add_row(OP_RD, 'h102, 0, 4'hf, 1);
		add_row(OP_RD, 'h102, 0, 4'hf, 2);
		add_row(OP_IRQ, 0, 0, 0, 0);
		add_row(OP_RD, 'h102, 0, 4'hf, 0);
		add_row(OP_WR, 'h100, 1, 4'hf, 0);
		add_row(OP_PULSE, 0, 2, 0, 0);
		add_row(OP_RD, 'h101, 0, 4'hf, 2);
		add_row(OP_WR, 'h101, 2, 4'hf, 0);
		add_row(OP_RD, 'h101, 0, 4'hf, 0);
		// Leave an enabled source pending across the warm reset
		add_row(OP_PULSE, 0, 1, 0, 1);
		// Warm reset keeps RAM contents
		add_row(OP_WR, 'h209, 32'hcafef00d, 4'hf, 0);
		add_row(OP_WR, 'h0ff, 2, 4'h1, 0);
		add_row(OP_WAITRST, 0, 0, 0, 0);
		add_row(OP_RD, 'h0ff, 0, 4'hf, 0);
		add_row(OP_RD, 'h209, 0, 4'hf, 32'hcafef00d);
		add_row(OP_RD, 'h100, 0, 4'hf, 0);
		add_row(OP_RD, 'h101, 0, 4'hf, 0);
		// Power-off holds until the board reset
		add_row(OP_WR, 'h0ff, 1, 4'h1, 0);
		add_row(OP_HOLD, 0, 40, 0, 1);
		add_row(OP_BOARD, 0, 0, 0, 0);
		add_row(OP_RD, 'h0ff, 0, 4'hf, 0);
		add_row(OP_RD, 'h209, 0, 4'hf, 32'hcafef00d);
	endtask

	initial begin
		wait (table_ready);
		#((t_op.size() * 40 + 6 * RST_CNT_CYCLES) * 20);
		$display("Run time limit reached before the table was done");
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [DATA_W-1:0] rd;
		void'($urandom(32'ha99d));
		rst_p = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		sel_i = '0;
		irq_src_i = '0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk48mhz_i);
		rst_p <= 1'b0;
		@(negedge clk48mhz_i);
		check_value("sys_rst_o after reset", sys_rst_o, 1);
		wait_release(1'b1);
		for (int i = 0; i < t_op.size(); i++) begin
			case (t_op[i])
				OP_RD: begin
					bus_access(1'b0, t_adr[i], '0, t_sel[i], rd);
					check_value($sformatf("read %h", t_adr[i]), rd, t_exp[i]);
				end
				OP_WR: bus_access(1'b1, t_adr[i], t_dat[i], t_sel[i], rd);
				OP_PULSE: begin
					@(posedge clk48mhz_i);
					irq_src_i <= t_dat[i][IRQ_SRC_COUNT-1:0];
					@(posedge clk48mhz_i);
					irq_src_i <= '0;
					@(posedge clk48mhz_i);
					@(negedge clk48mhz_i);
					check_value("irq_o after pulse", irq_o, t_exp[i]);
				end
				OP_IRQ: begin
					@(negedge clk48mhz_i);
					check_value("irq_o", irq_o, t_exp[i]);
				end
				OP_WAITRST: begin
					@(negedge clk48mhz_i);
					check_value("sys_rst_o after warm reset", sys_rst_o, 1);
					wait_release(1'b0);
				end
				OP_HOLD: begin
					repeat (t_dat[i]) begin
						@(negedge clk48mhz_i);
						check_value("sys_rst_o held", sys_rst_o, t_exp[i]);
					end
				end
				default: board_reset();
			endcase
		end
		repeat (2) @(posedge clk48mhz_i);
		errors += dut_i.chk_i.fail_count;
		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
common/soc_pkg.sv
hdl/bus_decode.sv
devtbl/devtbl.sv
hdl/reset_seq.sv
intctrl/intctrl.sv
hdl/scratch_ram.sv
hdl/soc_top.sv
bench/soc_chk.sv
bench/soc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, fail if the log reports failing checks
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module soc_tb -o soc_sim
./obj_dir/soc_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Checks failed" sim.log; then
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	exit 1
fi
exit 0
